//--- rtl/elink_cfg.svh
`ifndef ELINK_CFG_SVH
`define ELINK_CFG_SVH

// clocks per 10b symbol
// 10 bits leave 2 per clock
`define ELINK_SYM_CYCLES 5

// cycles after data_req in which the source may answer
// covers offsets 0 to 2
`define ELINK_REQ_WINDOW 3

// serial bit order on the line
// 1 sends bit a first on edata[0]
// 0 sends bit j first instead
`define ELINK_LSB_FIRST 1

`endif

//--- rtl/elink_pkg.sv
`default_nettype none

package elink_pkg;

  // delimiter kinds carried in the top 2 bits of a word
  typedef enum logic [1:0] {
    DELIM_DATA = 2'b00, // plain data byte
    DELIM_EOP  = 2'b01, // end of packet as K28.6
    DELIM_SOP  = 2'b10, // start of packet as K28.1
    DELIM_IDLE = 2'b11  // idle comma K28.5
  } delim_e;

  // data view splits the byte HGF / EDCBA
  typedef struct packed {
    delim_e     delim;
    logic [2:0] y;      // HGF for 3b/4b
    logic [4:0] x;      // EDCBA for 5b/6b
  } word_data_t;

  // ctrl view ignores the byte
  typedef struct packed {
    delim_e     delim;
    logic [7:0] dont_care;
  } word_ctrl_t;

  typedef union packed {
    word_data_t data;
    word_ctrl_t ctrl;
  } elink_word_u;

  typedef struct packed {
    logic       is_k;   // control symbol
    delim_e     kind;
    logic [4:0] x;
    logic [2:0] y;
    logic       valid;  // one cycle strobe
  } dec_word_t;

  // a in bit 0, j in bit 9
  typedef struct packed {
    logic [3:0] code4;  // f..j, f lowest
    logic [5:0] code6;  // a..i, a lowest
  } sym_t;

endpackage

`default_nettype wire

//--- rtl/elink_word_decode.sv
`timescale 1ns/1ps
`default_nettype none

module elink_word_decode (
  input  logic                   getDataTrig,
  input  logic                   rst,
  input  logic                   word_valid,
  input  elink_pkg::elink_word_u word,
  input  logic                   req_open,
  output elink_pkg::dec_word_t   dec
);

  logic              take;     // word inside the request window
  logic              valid_q;
  logic              is_k_q;
  elink_pkg::delim_e kind_q;
  logic [4:0]        x_q;
  logic [2:0]        y_q;

  // late or early words are dropped here
  // the serializer flags them
  assign take = word_valid && req_open;

  always_ff @(posedge getDataTrig)
  begin
    if (rst)
    begin
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= take; // strobe one cycle after word_valid
    end
  end

  // payload only moves on an accepted word
  always_ff @(posedge getDataTrig)
  begin
    if (take)
    begin
      kind_q <= word.ctrl.delim;
      is_k_q <= (word.ctrl.delim != elink_pkg::DELIM_DATA); // every non data kind
      x_q    <= word.data.x; // EDCBA
      y_q    <= word.data.y; // HGF
    end
  end

  assign dec = '{
    is_k:  is_k_q,
    kind:  kind_q,
    x:     x_q,
    y:     y_q,
    valid: valid_q
  };

endmodule

`default_nettype wire

//--- rtl/enc8b10b_execute.sv
`timescale 1ns/1ps
`default_nettype none

module enc8b10b_execute (
  input  logic                 getDataTrig,
  input  logic                 rst,
  input  elink_pkg::dec_word_t dec,
  input  logic                 sym_take,
  output elink_pkg::sym_t      sym,
  output logic                 sym_pending
);

  // K codes at negative disparity, written abcdei fghj with a as msb
  localparam logic [9:0] K28_1_NEG = 10'b001111_1001;
  localparam logic [9:0] K28_5_NEG = 10'b001111_1010;
  localparam logic [9:0] K28_6_NEG = 10'b001111_0110;

  logic            rd_pos;     // running disparity, 1 is positive
  logic            pend;
  elink_pkg::sym_t sym_q;      // encoded word waiting for the load
  logic [5:0]      six_n;
  logic [5:0]      six;
  logic            rd_mid;     // disparity between the two halves
  logic            use_a7;
  logic [3:0]      four_n;
  logic [3:0]      four;
  logic            data_rd;
  logic [9:0]      k_neg;
  logic [9:0]      enc_code;
  logic            enc_rd;
  elink_pkg::sym_t enc_sym;
  logic [9:0]      comma_code;
  elink_pkg::sym_t comma_sym;

  // 5b/6b at RD-, abcdei with a as msb
  function automatic logic [5:0] code6_neg(input logic [4:0] x);
    logic [5:0] c;
    case (x)
      5'd0:  c = 6'b100111;
      5'd1:  c = 6'b011101;
      5'd2:  c = 6'b101101;
      5'd3:  c = 6'b110001;
      5'd4:  c = 6'b110101;
      5'd5:  c = 6'b101001;
      5'd6:  c = 6'b011001;
      5'd7:  c = 6'b111000;
      5'd8:  c = 6'b111001;
      5'd9:  c = 6'b100101;
      5'd10: c = 6'b010101;
      5'd11: c = 6'b110100;
      5'd12: c = 6'b001101;
      5'd13: c = 6'b101100;
      5'd14: c = 6'b011100;
      5'd15: c = 6'b010111;
      5'd16: c = 6'b011011;
      5'd17: c = 6'b100011;
      5'd18: c = 6'b010011;
      5'd19: c = 6'b110010;
      5'd20: c = 6'b001011;
      5'd21: c = 6'b101010;
      5'd22: c = 6'b011010;
      5'd23: c = 6'b111010;
      5'd24: c = 6'b110011;
      5'd25: c = 6'b100110;
      5'd26: c = 6'b010110;
      5'd27: c = 6'b110110;
      5'd28: c = 6'b001110;
      5'd29: c = 6'b101110;
      5'd30: c = 6'b011110;
      5'd31: c = 6'b101011;
    endcase
    return c;
  endfunction

  // codes whose RD+ form is the complement, D.07 included
  function automatic logic alt6(input logic [4:0] x);
    return x inside {5'd0, 5'd1, 5'd2, 5'd4, 5'd7, 5'd8, 5'd15, 5'd16,
                     5'd23, 5'd24, 5'd27, 5'd29, 5'd30, 5'd31};
  endfunction

  // 3b/4b at RD-, fghj with f as msb
  function automatic logic [3:0] code4_neg(input logic [2:0] y);
    logic [3:0] c;
    case (y)
      3'd0: c = 4'b1011;
      3'd1: c = 4'b1001;
      3'd2: c = 4'b0101;
      3'd3: c = 4'b1100;
      3'd4: c = 4'b1101;
      3'd5: c = 4'b1010;
      3'd6: c = 4'b0110;
      3'd7: c = 4'b1110; // primary 7
    endcase
    return c;
  endfunction

  always_comb
  begin
    six_n  = code6_neg(dec.x);
    six    = (rd_pos && alt6(dec.x)) ? ~six_n : six_n;
    rd_mid = rd_pos ^ ($countones(six_n) != 3); // unbalanced 6b flips
    // A7 avoids a run of five across the i/f boundary
    use_a7 = (dec.y == 3'd7) &&
             ((!rd_mid && (dec.x inside {5'd17, 5'd18, 5'd20})) ||
              ( rd_mid && (dec.x inside {5'd11, 5'd13, 5'd14})));
    four_n  = use_a7 ? 4'b0111 : code4_neg(dec.y);
    four    = (rd_mid && (dec.y inside {3'd0, 3'd3, 3'd4, 3'd7})) ? ~four_n : four_n;
    data_rd = rd_mid ^ ($countones(four_n) != 2);
    case (dec.kind)
      elink_pkg::DELIM_SOP: k_neg = K28_1_NEG;
      elink_pkg::DELIM_EOP: k_neg = K28_6_NEG;
      default:              k_neg = K28_5_NEG; // idle
    endcase
    if (dec.is_k)
    begin
      enc_code = rd_pos ? ~k_neg : k_neg;
      enc_rd   = ~rd_pos; // all three K codes flip
    end
    else
    begin
      enc_code = {six, four};
      enc_rd   = data_rd;
    end
  end

  assign enc_sym    = {<<{enc_code}}; // a to bit 0
  assign comma_code = rd_pos ? ~K28_5_NEG : K28_5_NEG;
  assign comma_sym  = {<<{comma_code}};

  always_ff @(posedge getDataTrig)
  begin
    if (rst)
    begin
      rd_pos <= 1'b0; // start at RD-
      pend   <= 1'b0;
    end
    else if (dec.valid)
    begin
      pend   <= 1'b1;
      rd_pos <= enc_rd;
    end
    else if (sym_take)
    begin
      pend <= 1'b0;
      if (!pend)
        rd_pos <= ~rd_pos; // filler comma went out
    end
  end

  always_ff @(posedge getDataTrig)
  begin
    if (dec.valid)
      sym_q <= enc_sym;
  end

  assign sym         = pend ? sym_q : comma_sym;
  assign sym_pending = pend;

  // one word per period, so the slot is always free again by then
  a_no_overrun: assert property (@(posedge getDataTrig) disable iff (rst)
    dec.valid |-> !pend)
    else $error("decoded word arrived while a symbol was still pending");

endmodule

`default_nettype wire

//--- rtl/elink_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "elink_cfg.svh"

module elink_serializer (
  input  logic            getDataTrig,
  input  logic            rst,
  input  elink_pkg::sym_t sym,
  input  logic            sym_pending,
  input  logic            word_valid,
  output logic            data_req,
  output logic            req_open,
  output logic            sym_take,
  output logic [1:0]      edata
);

  localparam int unsigned SYM_CYCLES = `ELINK_SYM_CYCLES;
  localparam int unsigned REQ_WINDOW = `ELINK_REQ_WINDOW;
  localparam bit          LSB_FIRST  = `ELINK_LSB_FIRST;
  localparam int unsigned PW         = $clog2(SYM_CYCLES);

  logic [PW-1:0] phase;
  logic          primed;    // first period done, requests may start
  logic [9:0]    sym_rev;
  logic [9:0]    sym_bits;  // symbol in line order, first beat lowest
  logic [7:0]    sreg;      // beats still to go
  logic          word_seen; // word taken this period

  assign sym_rev  = {<<{sym}};
  assign sym_bits = LSB_FIRST ? sym : sym_rev;

  assign sym_take = (phase == '0); // load point
  assign data_req = primed && (phase == PW'(1)); // first beat of the period
  // open from data_req for REQ_WINDOW cycles
  assign req_open = primed && (phase != '0) && (phase <= PW'(REQ_WINDOW));

  always_ff @(posedge getDataTrig)
  begin
    if (rst)
    begin
      phase     <= '0;
      primed    <= 1'b0;
      edata     <= 2'b00;
      word_seen <= 1'b0;
    end
    else
    begin
      if (phase == PW'(SYM_CYCLES - 1))
      begin
        phase  <= '0;
        primed <= 1'b1;
      end
      else
        phase <= phase + 1'b1;
      // first beat goes out right behind the load edge
      if (sym_take)
        edata <= sym_bits[1:0];
      else
        edata <= sreg[1:0];
      if (sym_take)
        word_seen <= 1'b0;
      else if (word_valid && req_open)
        word_seen <= 1'b1;
    end
  end

  always_ff @(posedge getDataTrig)
  begin
    if (sym_take)
      sreg <= sym_bits[9:2];
    else
      sreg <= {2'b00, sreg[7:2]}; // next beat down
  end

  // source answers inside the window and only once per period
  a_req_window: assert property (@(posedge getDataTrig) disable iff (rst)
    word_valid |-> (req_open && !word_seen))
    else $error("word_valid outside the request window or repeated");

  // decode plus encode must finish before the next load
  a_word_ready: assert property (@(posedge getDataTrig) disable iff (rst)
    (sym_take && word_seen) |-> sym_pending)
    else $error("accepted word not pending at the symbol load");

endmodule

`default_nettype wire

//--- rtl/elink_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

module elink_tx_top (
  input  logic                   getDataTrig,
  input  logic                   rst,
  input  logic                   word_valid,
  input  elink_pkg::elink_word_u word,
  output logic                   data_req,
  output logic [1:0]             edata
);

  elink_pkg::dec_word_t dec;         // decode to execute
  elink_pkg::sym_t      sym;         // pending word or comma
  logic                 sym_pending;
  logic                 sym_take;    // load strobe back to execute
  logic                 req_open;    // window back to decode

  elink_word_decode u_decode (
    .getDataTrig (getDataTrig),
    .rst         (rst),
    .word_valid  (word_valid),
    .word        (word),
    .req_open    (req_open),
    .dec         (dec)
  );

  enc8b10b_execute u_execute (
    .getDataTrig (getDataTrig),
    .rst         (rst),
    .dec         (dec),
    .sym_take    (sym_take),
    .sym         (sym),
    .sym_pending (sym_pending)
  );

  elink_serializer u_serializer (
    .getDataTrig (getDataTrig),
    .rst         (rst),
    .sym         (sym),
    .sym_pending (sym_pending),
    .word_valid  (word_valid),
    .data_req    (data_req),
    .req_open    (req_open),
    .sym_take    (sym_take),
    .edata       (edata)
  );

endmodule

`default_nettype wire

//--- testbench/tb_enc8b10b_ref.svh
`ifndef TB_ENC8B10B_REF_SVH
`define TB_ENC8B10B_REF_SVH

// 5b/6b at RD-, abcdei with a as msb, indexed by EDCBA
localparam logic [5:0] CODE6_NEG [0:31] = '{
  6'b100111, 6'b011101, 6'b101101, 6'b110001,
  6'b110101, 6'b101001, 6'b011001, 6'b111000,
  6'b111001, 6'b100101, 6'b010101, 6'b110100,
  6'b001101, 6'b101100, 6'b011100, 6'b010111,
  6'b011011, 6'b100011, 6'b010011, 6'b110010,
  6'b001011, 6'b101010, 6'b011010, 6'b111010,
  6'b110011, 6'b100110, 6'b010110, 6'b110110,
  6'b001110, 6'b101110, 6'b011110, 6'b101011
};

// 3b/4b at RD-, fghj with f as msb, indexed by HGF
localparam logic [3:0] CODE4_NEG [0:7] = '{
  4'b1011, 4'b1001, 4'b0101, 4'b1100,
  4'b1101, 4'b1010, 4'b0110, 4'b1110  // primary 7
};

// one byte to 10b, result has a in bit 0
// rd 0 means RD-, K path only covers K28.y
function automatic logic [9:0] enc8b10b_ref(input  logic [7:0] val,
                                            input  logic       k,
                                            input  logic       rd_in,
                                            output logic       rd_out);
  logic [5:0] c6;
  logic [3:0] c4;
  logic       rd_mid;  // after the 6b block
  logic [9:0] code;    // a as msb
  logic [9:0] sym;
  c4 = CODE4_NEG[val[7:5]];
  if (k)
  begin
    code = {6'b001111, c4}; // K28 at RD-
    if (rd_in)
      code = ~code; // whole symbol mirrors at RD+
  end
  else
  begin
    c6 = CODE6_NEG[val[4:0]];
    if (rd_in && (($countones(c6) != 3) || (val[4:0] == 5'd7)))
      c6 = ~c6;
    rd_mid = ($countones(c6) == 3) ? rd_in : ($countones(c6) > 3);
    if (rd_mid && (($countones(c4) != 2) || (val[7:5] == 3'd3)))
      c4 = ~c4;
    // e, i and f all equal would give a run of five
    if ((val[7:5] == 3'd7) && (c6[1] == c6[0]) && (c6[0] == c4[3]))
      c4 = rd_mid ? 4'b1000 : 4'b0111; // A7
    code = {c6, c4};
  end
  rd_out = ($countones(code) == 5) ? rd_in : ($countones(code) > 5);
  for (int i = 0; i < 10; i++)
    sym[i] = code[9 - i]; // a to bit 0
  return sym;
endfunction

`endif

//--- testbench/tb_elink_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "elink_cfg.svh"

module tb_elink_tx;

  `include "tb_enc8b10b_ref.svh"

  localparam int          SYM_CYCLES = `ELINK_SYM_CYCLES;
  localparam bit          LSB_FIRST  = `ELINK_LSB_FIRST;
  localparam logic [31:0] LFSR_SEED  = 32'h29f91c96;
  localparam logic [31:0] LFSR_TAPS  = 32'h80200003; // x^32 + x^22 + x^2 + x + 1
  localparam int N_IDLE  = 4;   // periods per section
  localparam int N_DATA  = 40;
  localparam int N_CTRL  = 12;
  localparam int N_MIX_A = 20;  // before the second reset
  localparam int N_MIX_B = 20;
  localparam int N_TAIL  = 3;
  // plus leading commas of both resets and the drain
  localparam int N_PERIODS = N_IDLE + N_DATA + N_CTRL + N_MIX_A + N_MIX_B + N_TAIL + 6;
  localparam int TIMEOUT_CYCLES = N_PERIODS * SYM_CYCLES + 50;
  localparam int MODE_EMPTY = 0;
  localparam int MODE_DATA  = 1;
  localparam int MODE_CTRL  = 2;
  localparam int MODE_MIXED = 3;

  logic                   getDataTrig;
  logic                   rst;
  logic                   word_valid;
  elink_pkg::elink_word_u word;
  logic                   data_req;
  logic [1:0]             edata;

  logic [31:0] lfsr_state;
  logic        model_rd;    // 0 is RD-
  logic [9:0]  exp_q [$];   // symbols in line order
  int          cycles;

  elink_tx_top dut (
    .getDataTrig (getDataTrig),
    .rst         (rst),
    .word_valid  (word_valid),
    .word        (word),
    .data_req    (data_req),
    .edata       (edata)
  );

  initial
  begin
    getDataTrig = 1'b0;
    forever #50 getDataTrig = ~getDataTrig; // 100 ns period
  end

  task automatic abort_run;
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERROR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // galois form, shifts right
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ LFSR_TAPS;
    return n;
  endfunction

  task automatic take_random(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[6:0], lfsr_state[0]}; // one step per bit
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic push_expected(input logic [7:0] val, input logic k);
    logic       rd_next;
    logic [9:0] sym;
    sym = enc8b10b_ref(val, k, model_rd, rd_next);
    model_rd = rd_next;
    exp_q.push_back(sym);
  endtask

  // returns on the falling edge that sees data_req
  task automatic wait_for_req;
    int n;
    n = 0;
    do
    begin
      @(negedge getDataTrig);
      n++;
      if (n > SYM_CYCLES + 2)
      begin
        $display("data_req did not pulse within %0d cycles", n - 1);
        abort_run();
      end
    end
    while (!data_req);
  endtask

  task automatic send_word(input logic [1:0] delim, input logic [7:0] val, input int offset);
    repeat (offset) @(negedge getDataTrig);
    word       = elink_pkg::elink_word_u'({delim, val});
    word_valid = 1'b1;
    @(negedge getDataTrig);
    word_valid = 1'b0; // single cycle strobe
  endtask

  task automatic run_periods(input int count, input int mode);
    logic [7:0] r;
    logic [7:0] val;
    logic [1:0] delim;
    logic       send;
    for (int i = 0; i < count; i++)
    begin
      wait_for_req();
      take_random(8, val);
      take_random(2, r);
      delim = r[1:0];
      send  = (mode != MODE_EMPTY);
      if (mode == MODE_DATA)
        delim = elink_pkg::DELIM_DATA;
      else if ((mode == MODE_CTRL) && (delim == elink_pkg::DELIM_DATA))
        delim = elink_pkg::DELIM_IDLE; // control kinds only
      if (mode == MODE_MIXED)
      begin
        take_random(1, r);
        send = r[0]; // some periods stay empty
      end
      if (send)
      begin
        case (delim)
          elink_pkg::DELIM_SOP:  push_expected(8'h3C, 1'b1); // K28.1
          elink_pkg::DELIM_EOP:  push_expected(8'hDC, 1'b1); // K28.6
          elink_pkg::DELIM_IDLE: push_expected(8'hBC, 1'b1); // K28.5
          default:               push_expected(val, 1'b0);
        endcase
        take_random(2, r);
        send_word(delim, val, int'(r[1:0]) % 3); // offset 0 to 2
      end
      else
        push_expected(8'hBC, 1'b1); // filler comma
    end
  endtask

  task automatic apply_reset;
    rst        = 1'b1;
    word_valid = 1'b0;
    repeat (8) @(negedge getDataTrig);
    exp_q.delete(); // anything in flight is lost
    model_rd = 1'b0;
    // two loads go out before the first request is answered
    push_expected(8'hBC, 1'b1);
    push_expected(8'hBC, 1'b1);
    rst = 1'b0;
  endtask

  initial
  begin
    cycles = 0;
    forever
    begin
      @(posedge getDataTrig);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES)
      begin
        $display("run timed out after %0d cycles", cycles);
        abort_run();
      end
    end
  end

  // rebuilds symbols from edata and checks data_req every cycle
  initial
  begin : compare_stream
    bit         live;
    int         beat;
    int         since_rst;  // cycles since the first load
    logic [9:0] line;       // first beat lowest
    logic [9:0] got;
    beat      = 0;
    since_rst = 0;
    line      = '0;
    forever
    begin
      @(posedge getDataTrig);
      live = !rst;
      @(negedge getDataTrig); // outputs settled
      if (!live)
      begin
        beat      = 0;
        since_rst = 0;
        check_value("data_req", data_req, 0);
        check_value("edata", edata, 0);
      end
      else
      begin
        check_value("data_req", data_req,
                    (since_rst >= SYM_CYCLES) && (since_rst % SYM_CYCLES == 0));
        line[2*beat +: 2] = edata;
        beat++;
        since_rst++;
        if (beat == SYM_CYCLES)
        begin
          beat = 0;
          for (int i = 0; i < 10; i++)
            got[i] = LSB_FIRST ? line[i] : line[9 - i];
          if (exp_q.size() == 0)
          begin
            $display("a symbol finished on edata with nothing expected");
            abort_run();
          end
          check_value("edata", got, exp_q.pop_front());
        end
      end
    end
  end

  initial
  begin
    lfsr_state = LFSR_SEED;
    model_rd   = 1'b0;
    word       = '0;
    apply_reset();
    run_periods(N_IDLE, MODE_EMPTY);  // commas only
    run_periods(N_DATA, MODE_DATA);
    run_periods(N_CTRL, MODE_CTRL);
    run_periods(N_MIX_A, MODE_MIXED);
    apply_reset();                    // word may still be pending here
    run_periods(N_MIX_B, MODE_MIXED);
    run_periods(N_TAIL, MODE_EMPTY);
    while (exp_q.size() != 0)
      @(negedge getDataTrig);
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+rtl
+incdir+testbench
rtl/elink_pkg.sv
rtl/elink_word_decode.sv
rtl/enc8b10b_execute.sv
rtl/elink_serializer.sv
rtl/elink_tx_top.sv
testbench/tb_elink_tx.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_elink_tx -f files.f \
  || { echo "build failed"; exit 1; }
./obj_dir/Vtb_elink_tx > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
